/* design/axis_cmd_if.sv */
`timescale 1ns/1ps

interface axis_cmd_if #(
	parameter type count_t = motor_pkg::steps_x_t
);
	import motor_pkg::*;

	logic start; // one cycle, qualifies dir/steps/width
	axis_dir_t dir;
	count_t steps;
	pulse_width_t width;
	logic busy; // high while the axis is stepping

	modport src (
		output start,
		output dir,
		output steps,
		output width,
		input busy
	);

	modport sink (
		input start,
		input dir,
		input steps,
		input width,
		output busy
	);

endinterface : axis_cmd_if

/* design/axis_stepper.sv */
`timescale 1ns/1ps

module axis_stepper #(
	parameter type count_t = motor_pkg::steps_x_t
) (
	input logic intf,
	input logic reset,
	input logic tick,
	axis_cmd_if.sink cmd,
	output logic out,
	output logic dir,
	output logic n_en
);
	import motor_pkg::*;

	typedef enum logic [1:0] {
		ph_wait, // waiting for the first tick
		ph_high,
		ph_low
	} phase_t;

	phase_t phase;
	logic busy_q;
	count_t steps_left; // includes the pulse in progress
	pulse_width_t width_q;
	pulse_width_t tick_cnt;
	logic last_tick;

	assign last_tick = tick && (tick_cnt == pulse_width_t'(1)); // phase ends on this tick

	assign cmd.busy = busy_q;
	assign n_en = ~busy_q; // driver enabled while moving

	always_ff @(posedge intf) begin
		if (reset) begin
			phase <= ph_wait;
			busy_q <= 1'b0;
			out <= 1'b0;
			dir <= 1'b0;
		end else if (cmd.start) begin
			dir <= cmd.dir;
			if (cmd.steps != '0) begin
				busy_q <= 1'b1;
				phase <= ph_wait;
			end
		end else if (busy_q) begin
			case (phase)
			ph_wait: begin
				if (tick) begin
					out <= 1'b1;
					phase <= ph_high;
				end
			end
			ph_high: begin
				if (last_tick) begin
					out <= 1'b0;
					phase <= ph_low;
				end
			end
			ph_low: begin
				if (last_tick) begin
					if (steps_left == count_t'(1)) begin
						busy_q <= 1'b0;
						phase <= ph_wait;
					end else begin
						out <= 1'b1; // next pulse starts on the same tick
						phase <= ph_high;
					end
				end
			end
			default: phase <= ph_wait;
			endcase
		end
	end

	always_ff @(posedge intf) begin
		if (cmd.start) begin
			steps_left <= cmd.steps;
			width_q <= cmd.width;
		end else if (busy_q) begin
			if (tick) begin
				if (phase == ph_wait || last_tick)
					tick_cnt <= width_q;
				else
					tick_cnt <= tick_cnt - 1'b1;
			end
			if (phase == ph_low && last_tick)
				steps_left <= steps_left - 1'b1;
		end
	end

	no_step_when_disabled: assert property (@(posedge intf) disable iff (reset)
		out |-> !n_en);

	// direction must hold for the whole move
	dir_stable_while_busy: assert property (@(posedge intf) disable iff (reset)
		busy_q |=> (!busy_q || $stable(dir)));

endmodule : axis_stepper

/* design/clk_en_divider.sv */
`timescale 1ns/1ps

module clk_en_divider (
	input logic intf,
	input logic reset,
	input ctrl_pkg::div_t clk_div,
	output logic tick
);
	import ctrl_pkg::*;

	div_t cnt;

	// reload only at terminal count, so a new clk_div waits for the current period
	always_ff @(posedge intf) begin
		if (reset) begin
			cnt <= '0;
			tick <= 1'b0;
		end else if (cnt == '0) begin
			cnt <= clk_div;
			tick <= 1'b1;
		end else begin
			cnt <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule : clk_en_divider

/* design/ctrl_pkg.sv */
`include "stepper_consts.svh"

package ctrl_pkg;

	// decode stage sequencing
	typedef enum logic [1:0] {
		idle,
		dispatch, // start pulse out to both axes
		run
	} cmd_state_t;

	typedef logic [`STEPPER_DIV_BITS-1:0] div_t;

endpackage : ctrl_pkg

/* design/motor_pkg.sv */
`include "stepper_consts.svh"

package motor_pkg;

	// signed commands, sign selects direction
	typedef logic signed [`STEPPER_PULSE_NUM_X_BITS-1:0] pulse_num_x_t;
	typedef logic signed [`STEPPER_PULSE_NUM_Y_BITS-1:0] pulse_num_y_t;

	// magnitudes, wide enough for the most negative command
	typedef logic [`STEPPER_PULSE_NUM_X_BITS-1:0] steps_x_t;
	typedef logic [`STEPPER_PULSE_NUM_Y_BITS-1:0] steps_y_t;

	typedef logic [`STEPPER_PULSE_WIDTH_BITS-1:0] pulse_width_t; // ticks per phase

	typedef enum logic {
		dir_neg = 1'b0,
		dir_pos = 1'b1
	} axis_dir_t;

endpackage : motor_pkg

/* design/stepper_cmd_stage.sv */
`timescale 1ns/1ps

module stepper_cmd_stage (
	input logic intf,
	input logic reset,
	input logic trigger,
	input motor_pkg::pulse_num_x_t pulse_num_x,
	input motor_pkg::pulse_num_y_t pulse_num_y,
	input motor_pkg::pulse_width_t pulse_width,
	output logic rdy,
	axis_cmd_if.src cmd_x,
	axis_cmd_if.src cmd_y
);
	import motor_pkg::*;
	import ctrl_pkg::*;

	cmd_state_t state;
	logic start_q; // shared by both axes
	logic accept;

	axis_dir_t dir_x_q;
	axis_dir_t dir_y_q;
	steps_x_t steps_x_q;
	steps_y_t steps_y_q;
	pulse_width_t width_q;

	assign accept = trigger && rdy; // rdy is only high in idle

	always_ff @(posedge intf) begin
		if (reset) begin
			state <= idle;
			rdy <= 1'b1;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			case (state)
			idle: begin
				if (accept) begin
					state <= dispatch;
					rdy <= 1'b0;
					start_q <= 1'b1;
				end
			end
			dispatch: state <= run; // busy is valid from here on
			run: begin
				if (!cmd_x.busy && !cmd_y.busy) begin
					state <= idle;
					rdy <= 1'b1;
				end
			end
			default: state <= idle;
			endcase
		end
	end

	// sign to direction and two's complement magnitude
	always_ff @(posedge intf) begin
		if (accept) begin
			dir_x_q <= (pulse_num_x < 0) ? dir_neg : dir_pos;
			dir_y_q <= (pulse_num_y < 0) ? dir_neg : dir_pos;
			steps_x_q <= (pulse_num_x < 0) ? steps_x_t'(-pulse_num_x) : steps_x_t'(pulse_num_x);
			steps_y_q <= (pulse_num_y < 0) ? steps_y_t'(-pulse_num_y) : steps_y_t'(pulse_num_y);
			width_q <= (pulse_width == '0) ? pulse_width_t'(1) : pulse_width; // 0 acts as 1
		end
	end

	assign cmd_x.start = start_q;
	assign cmd_x.dir = dir_x_q;
	assign cmd_x.steps = steps_x_q;
	assign cmd_x.width = width_q;

	assign cmd_y.start = start_q;
	assign cmd_y.dir = dir_y_q;
	assign cmd_y.steps = steps_y_q;
	assign cmd_y.width = width_q;

	// rdy high means no command goes out and both axes are idle
	no_start_or_busy_while_rdy: assert property (@(posedge intf) disable iff (reset)
		rdy |-> !cmd_x.start && !cmd_y.start && !cmd_x.busy && !cmd_y.busy);

	// an axis must have finished before it sees a new command
	no_start_while_busy_x: assert property (@(posedge intf) disable iff (reset)
		cmd_x.start |-> !cmd_x.busy);
	no_start_while_busy_y: assert property (@(posedge intf) disable iff (reset)
		cmd_y.start |-> !cmd_y.busy);

endmodule : stepper_cmd_stage

/* design/stepper_ctrl_xy.sv */
`timescale 1ns/1ps

module stepper_ctrl_xy (
	input logic intf,
	input logic reset,
	input ctrl_pkg::div_t clk_div,
	input logic trigger,
	input motor_pkg::pulse_num_x_t pulse_num_x,
	input motor_pkg::pulse_num_y_t pulse_num_y,
	input motor_pkg::pulse_width_t pulse_width,
	output logic rdy,
	output logic out_x,
	output logic dir_x,
	output logic n_en_x,
	output logic out_y,
	output logic dir_y,
	output logic n_en_y
);
	import motor_pkg::*;

	logic tick; // step timebase for both axes

	axis_cmd_if #(.count_t(steps_x_t)) cmd_x ();
	axis_cmd_if #(.count_t(steps_y_t)) cmd_y ();

	clk_en_divider div_inst (
		.intf(intf),
		.reset(reset),
		.clk_div(clk_div),
		.tick(tick)
	);

	stepper_cmd_stage cmd_inst (
		.intf(intf),
		.reset(reset),
		.trigger(trigger),
		.pulse_num_x(pulse_num_x),
		.pulse_num_y(pulse_num_y),
		.pulse_width(pulse_width),
		.rdy(rdy),
		.cmd_x(cmd_x.src),
		.cmd_y(cmd_y.src)
	);

	axis_stepper #(
		.count_t(steps_x_t)
	) stepper_x (
		.intf(intf),
		.reset(reset),
		.tick(tick),
		.cmd(cmd_x.sink),
		.out(out_x),
		.dir(dir_x),
		.n_en(n_en_x)
	);

	axis_stepper #(
		.count_t(steps_y_t)
	) stepper_y (
		.intf(intf),
		.reset(reset),
		.tick(tick),
		.cmd(cmd_y.sink),
		.out(out_y),
		.dir(dir_y),
		.n_en(n_en_y)
	);

endmodule : stepper_ctrl_xy

/* filelist.f */
+incdir+include
design/motor_pkg.sv
design/ctrl_pkg.sv
design/axis_cmd_if.sv
design/clk_en_divider.sv
design/stepper_cmd_stage.sv
design/axis_stepper.sv
design/stepper_ctrl_xy.sv
verification/stepper_ctrl_xy_tb.sv

/* include/stepper_consts.svh */
`ifndef STEPPER_CONSTS_SVH
`define STEPPER_CONSTS_SVH

// signed pulse count widths per axis
`define STEPPER_PULSE_NUM_X_BITS 16
`define STEPPER_PULSE_NUM_Y_BITS 12

// step high/low time, in divider ticks
`define STEPPER_PULSE_WIDTH_BITS 8

`define STEPPER_DIV_BITS 8 // tick every clk_div+1 clocks

`define STEPPER_PULSE_WIDTH 4 // default pulse width

`endif

/* verification/stepper_ctrl_xy_tb.sv */
`timescale 1ns/1ps

module stepper_ctrl_xy_tb;
	import motor_pkg::*;
	import ctrl_pkg::*;

	localparam int n_fixed = 8;
	localparam int n_rows = 12;
	localparam int clk_period = 8;

	logic intf = 1'b0;
	logic reset;
	div_t clk_div;
	logic trigger;
	pulse_num_x_t pulse_num_x;
	pulse_num_y_t pulse_num_y;
	pulse_width_t pulse_width;
	logic rdy;
	logic out_x;
	logic dir_x;
	logic n_en_x;
	logic out_y;
	logic dir_y;
	logic n_en_y;

	// stimulus columns, then expected columns
	int tab_x [n_rows];
	int tab_y [n_rows];
	int tab_width [n_rows];
	int tab_div [n_rows];
	bit tab_hold [n_rows]; // keep trigger high while the axes run
	int tab_exp_x [n_rows];
	int tab_exp_y [n_rows];
	logic tab_dir_x [n_rows];
	logic tab_dir_y [n_rows];
	int tab_exp_high [n_rows];

	// monitor state, index 0 is x and 1 is y
	logic out_prev [2] = '{1'b0, 1'b0};
	int rise_cnt [2];
	int high_len [2];
	int exp_cnt [2];
	logic exp_dir [2];
	int exp_high;
	bit in_cmd = 1'b0;

	int test_errors = 0;
	int errors = 0;
	int n_tests = 0;
	int n_failed = 0;
	longint timeout_ns = 0;

	stepper_ctrl_xy stepper_ctrl_xy_inst (
		.intf(intf),
		.reset(reset),
		.clk_div(clk_div),
		.trigger(trigger),
		.pulse_num_x(pulse_num_x),
		.pulse_num_y(pulse_num_y),
		.pulse_width(pulse_width),
		.rdy(rdy),
		.out_x(out_x),
		.dir_x(dir_x),
		.n_en_x(n_en_x),
		.out_y(out_y),
		.dir_y(dir_y),
		.n_en_y(n_en_y)
	);

	always #(clk_period / 2) intf = ~intf;

	function automatic int magnitude(input int v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic int larger(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Error: %s expected %0h actual %0h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic set_row(input int i, input int x, input int y, input int w, input int d,
		input bit hold);
		tab_x[i] = x;
		tab_y[i] = y;
		tab_width[i] = w;
		tab_div[i] = d;
		tab_hold[i] = hold;
		tab_exp_x[i] = magnitude(x);
		tab_exp_y[i] = magnitude(y);
		tab_dir_x[i] = (x >= 0); // positive level for zero and up
		tab_dir_y[i] = (y >= 0);
		tab_exp_high[i] = larger(w, 1) * (d + 1);
	endtask

	task automatic watch_axis(input int ax, input logic out_v, input logic dir_v,
		input logic n_en_v);
		string sfx;
		sfx = (ax == 0) ? "x" : "y";
		if (out_v && !out_prev[ax]) begin
			rise_cnt[ax]++;
			high_len[ax] = 1;
			check_value({"dir_", sfx}, exp_dir[ax], dir_v);
			check_value({"n_en_", sfx}, 0, n_en_v);
		end else if (out_v) begin
			high_len[ax]++;
		end else if (out_prev[ax]) begin
			check_value({"out_", sfx, " high cycles"}, exp_high, high_len[ax]);
		end
		if (in_cmd && exp_cnt[ax] == 0)
			check_value({"n_en_", sfx}, 1, n_en_v); // idle axis keeps its driver off
		out_prev[ax] = out_v;
	endtask

	always @(negedge intf) begin
		watch_axis(0, out_x, dir_x, n_en_x);
		watch_axis(1, out_y, dir_y, n_en_y);
	end

	task run_row(input int i);
		int settle;
		@(posedge intf);
		#1;
		test_errors = 0;
		settle = int'(clk_div) + 2; // old period has to run out before the reload
		clk_div = div_t'(tab_div[i]);
		pulse_num_x = pulse_num_x_t'(tab_x[i]);
		pulse_num_y = pulse_num_y_t'(tab_y[i]);
		pulse_width = pulse_width_t'(tab_width[i]);
		repeat (settle) @(posedge intf);
		#1;
		exp_cnt[0] = tab_exp_x[i];
		exp_cnt[1] = tab_exp_y[i];
		exp_dir[0] = tab_dir_x[i];
		exp_dir[1] = tab_dir_y[i];
		exp_high = tab_exp_high[i];
		rise_cnt[0] = 0;
		rise_cnt[1] = 0;
		check_value("rdy", 1, rdy);
		trigger = 1'b1;
		@(posedge intf);
		#1;
		check_value("rdy", 0, rdy);
		in_cmd = 1'b1;
		if (!tab_hold[i])
			trigger = 1'b0;
		while (!rdy) begin
			@(posedge intf);
			#1;
		end
		trigger = 1'b0;
		in_cmd = 1'b0;
		check_value("n_en_x", 1, n_en_x);
		check_value("n_en_y", 1, n_en_y);
		repeat (3) @(posedge intf); // a held trigger must not start another move
		#1;
		check_value("rdy", 1, rdy);
		check_value("out_x count", exp_cnt[0], rise_cnt[0]);
		check_value("out_y count", exp_cnt[1], rise_cnt[1]);
		check_value("dir_x", exp_dir[0], dir_x);
		check_value("dir_y", exp_dir[1], dir_y);
		check_value("out_x", 0, out_x);
		check_value("out_y", 0, out_y);
		n_tests++;
		errors += test_errors;
		if (test_errors != 0)
			n_failed++;
		$display("test %0d x=%0d y=%0d width=%0d div=%0d hold=%0d: %s", i + 1, tab_x[i],
			tab_y[i], tab_width[i], tab_div[i], tab_hold[i],
			(test_errors == 0) ? "ok" : "fail");
	endtask

	initial begin
		wait (timeout_ns != 0);
		#(timeout_ns);
		$display("watchdog: run timed out after %0d ns", timeout_ns);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		longint budget;
		reset = 1'b1;
		trigger = 1'b0;
		clk_div = '0;
		pulse_num_x = '0;
		pulse_num_y = '0;
		pulse_width = '0;
		void'($urandom(32'h7821));

		set_row(0, -3, 0, 1, 0, 0); // x only
		set_row(1, 0, 2, 2, 1, 0); // y only
		set_row(2, 5, -4, 3, 2, 0);
		set_row(3, 0, -2048, 0, 0, 0); // most negative y, width 0
		set_row(4, 2, 3, 0, 3, 0);
		set_row(5, 0, 0, 2, 1, 0);
		set_row(6, 4, -1, 1, 5, 1);
		set_row(7, -7, 6, 4, 2, 1);
		for (int i = n_fixed; i < n_rows; i++)
			set_row(i, int'($urandom % 17) - 8, int'($urandom % 17) - 8, int'($urandom % 5),
				int'($urandom % 4), bit'($urandom % 2));

		budget = 0;
		for (int i = 0; i < n_rows; i++)
			budget += 2 * larger(tab_exp_x[i], tab_exp_y[i]) * tab_exp_high[i] + 20;
		timeout_ns = budget * clk_period * 2;

		repeat (10) @(posedge intf);
		#1;
		reset = 1'b0;
		@(negedge intf);
		check_value("rdy", 1, rdy);
		check_value("n_en_x", 1, n_en_x);
		check_value("n_en_y", 1, n_en_y);
		check_value("out_x", 0, out_x);
		check_value("out_y", 0, out_y);
		check_value("dir_x", 0, dir_x);
		check_value("dir_y", 0, dir_y);
		n_tests++;
		errors += test_errors;
		if (test_errors != 0)
			n_failed++;
		$display("test 0 reset values: %s", (test_errors == 0) ? "ok" : "fail");

		for (int i = 0; i < n_rows; i++)
			run_row(i);

		$display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
		if (errors == 0 && n_failed == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule : stepper_ctrl_xy_tb
